/* mag_pkg.sv */
// Magnitude comparator shared types
// Operand, leading-one index and the ordered pair that flows through the FIFO

`default_nettype none

package mag_pkg;

    // Operand and difference width
    localparam int operand_width = 16;

    // Bits needed to name any bit position of an operand
    localparam int index_width = $clog2(operand_width);

    // Entries in the pair buffer between the two stages
    localparam int fifo_depth = 4;

    // Unsigned operand, also used for the difference
    typedef logic [operand_width-1:0] operand_t;

    // Position of the leading one
    typedef logic [index_width-1:0] msb_index_t;

    // Pair after sorting, larger operand first
    typedef struct packed {
        operand_t larger;
        operand_t smaller;
        // Set only when a was strictly greater than b
        logic     a_larger;
    } ordered_pair_t;

endpackage

`default_nettype wire

/* prefix_adder.sv */
// Ripple carry adder built from generate/propagate terms
// Any width, carry in and carry out exposed

`timescale 1ns/1ps
`default_nettype none

module prefix_adder #(
    parameter int width = 8
) (
    input  logic [width-1:0] a,
    input  logic [width-1:0] b,
    input  logic             cin,
    output logic [width-1:0] sum,
    output logic             cout
);

    logic [width-1:0] gen;
    logic [width-1:0] prop;
    // carry[i] is the carry into bit i
    logic [width:0]   carry;

    // Per-bit generate and propagate
    assign gen  = a & b;
    assign prop = a ^ b;

    assign carry[0] = cin;

    // Carry ripples one bit at a time
    for (genvar i = 0; i < width; i++) begin : g_carry
        // Bit i makes a carry or passes the incoming one along
        assign carry[i+1] = gen[i] | (prop[i] & carry[i]);
    end

    // Sum bit is propagate xor the carry coming in
    assign sum  = prop ^ carry[width-1:0];
    assign cout = carry[width];

endmodule

`default_nettype wire

/* pair_sorter.sv */
// Producer stage of the magnitude stream
// Compares each operand pair and registers it as larger/smaller with the a_larger flag

`timescale 1ns/1ps
`default_nettype none

module pair_sorter (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  mag_pkg::operand_t      in_a,
    input  mag_pkg::operand_t      in_b,
    output logic                   out_valid,
    input  logic                   out_ready,
    output mag_pkg::ordered_pair_t out_pair
);

    import mag_pkg::*;

    logic          a_gt_b;
    ordered_pair_t sorted;
    logic          take_in;

    // Strict compare, a tie counts as b larger
    assign a_gt_b = in_a > in_b;

    // Order the pair before it is stored
    always_comb begin
        sorted.a_larger = a_gt_b;
        if (a_gt_b) begin
            sorted.larger  = in_a;
            sorted.smaller = in_b;
        end else begin
            sorted.larger  = in_b;
            sorted.smaller = in_a;
        end
    end

    // Stage is free when empty or drained this cycle
    assign in_ready = !out_valid || out_ready;
    assign take_in  = in_valid && in_ready;

    // Valid bit of the single register stage
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            // Refill or empty, depending on the source
            out_valid <= in_valid;
        end
    end

    // Payload, loaded only on a real transfer
    always_ff @(posedge clk) begin
        if (take_in) begin
            out_pair <= sorted;
        end
    end

endmodule

`default_nettype wire

/* pair_fifo.sv */
// Circular-buffer FIFO of ordered pairs
// Valid/ready on both sides, full and empty taken from the occupancy count

`timescale 1ns/1ps
`default_nettype none

module pair_fifo (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   wr_valid,
    output logic                   wr_ready,
    input  mag_pkg::ordered_pair_t wr_pair,
    output logic                   rd_valid,
    input  logic                   rd_ready,
    output mag_pkg::ordered_pair_t rd_pair
);

    import mag_pkg::*;

    // Storage array
    ordered_pair_t                       mem [fifo_depth];
    logic [$clog2(fifo_depth)-1:0]       wr_ptr;
    logic [$clog2(fifo_depth)-1:0]       rd_ptr;
    // One wider than the pointers so a full buffer can be counted
    logic [$clog2(fifo_depth+1)-1:0]     count;
    logic                                do_wr;
    logic                                do_rd;

    // Readiness from the count alone, so no write slips in while full
    assign wr_ready = count != fifo_depth;
    assign rd_valid = count != 0;

    assign do_wr = wr_valid && wr_ready;
    assign do_rd = rd_valid && rd_ready;

    // Head entry straight out of the array
    assign rd_pair = mem[rd_ptr];

    // Pointers and count
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                // Wrap at the last entry, depth need not be a power of two
                if (wr_ptr == fifo_depth - 1) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (do_rd) begin
                if (rd_ptr == fifo_depth - 1) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
            // Count moves only when exactly one side transfers
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

    // Write port of the array
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_pair;
        end
    end

endmodule

`default_nettype wire

/* magnitude_unit.sv */
// Consumer stage of the magnitude stream
// Subtracts smaller from larger, finds the leading one and registers the result

`timescale 1ns/1ps
`default_nettype none

module magnitude_unit (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  mag_pkg::ordered_pair_t in_pair,
    output logic                   out_valid,
    input  logic                   out_ready,
    output mag_pkg::operand_t      out_diff,
    output mag_pkg::msb_index_t    out_msb,
    output logic                   out_a_larger
);

    import mag_pkg::*;

    operand_t   diff;
    msb_index_t msb;
    logic       take_in;

    // Highest set bit, 0 when nothing is set
    function automatic msb_index_t find_msb(input operand_t value);
        msb_index_t idx;
        idx = '0;
        // Upward scan, the last hit is the highest bit
        for (int i = 0; i < operand_width; i++) begin
            if (value[i]) begin
                idx = msb_index_t'(i);
            end
        end
        return idx;
    endfunction

    // larger + ~smaller + 1, never negative since the pair is ordered
    prefix_adder #(
        .width (operand_width)
    ) sub0 (
        .a    (in_pair.larger),
        .b    (~in_pair.smaller),
        .cin  (1'b1),
        .sum  (diff),
        // Always set for an ordered pair
        .cout ()
    );

    assign msb = find_msb(diff);

    // Same ready rule as the producer stage
    assign in_ready = !out_valid || out_ready;
    assign take_in  = in_valid && in_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    // Difference, index and flag move together
    always_ff @(posedge clk) begin
        if (take_in) begin
            out_diff     <= diff;
            out_msb      <= msb;
            out_a_larger <= in_pair.a_larger;
        end
    end

endmodule

`default_nettype wire

/* mag_stream_top.sv */
// Streaming magnitude comparator top level
// Sorter, pair FIFO and magnitude unit in a valid/ready chain

`timescale 1ns/1ps
`default_nettype none

module mag_stream_top (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                in_valid,
    output logic                in_ready,
    input  mag_pkg::operand_t   in_a,
    input  mag_pkg::operand_t   in_b,
    output logic                out_valid,
    input  logic                out_ready,
    output mag_pkg::operand_t   out_diff,
    output mag_pkg::msb_index_t out_msb,
    output logic                out_a_larger
);

    import mag_pkg::*;

    // Sorter to FIFO
    logic          sort_valid;
    logic          sort_ready;
    ordered_pair_t sort_pair;

    // FIFO to magnitude unit
    logic          buf_valid;
    logic          buf_ready;
    ordered_pair_t buf_pair;

    pair_sorter sort0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_a      (in_a),
        .in_b      (in_b),
        .out_valid (sort_valid),
        .out_ready (sort_ready),
        .out_pair  (sort_pair)
    );

    // Absorbs back-pressure from the output side
    pair_fifo fifo0 (
        .clk      (clk),
        .arst_n   (arst_n),
        .wr_valid (sort_valid),
        .wr_ready (sort_ready),
        .wr_pair  (sort_pair),
        .rd_valid (buf_valid),
        .rd_ready (buf_ready),
        .rd_pair  (buf_pair)
    );

    magnitude_unit mag0 (
        .clk          (clk),
        .arst_n       (arst_n),
        .in_valid     (buf_valid),
        .in_ready     (buf_ready),
        .in_pair      (buf_pair),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_diff     (out_diff),
        .out_msb      (out_msb),
        .out_a_larger (out_a_larger)
    );

endmodule

`default_nettype wire

/* mag_stream_props.sv */
// Handshake, reset and leading-one assertions for the magnitude stream
// Bound into the top level

`timescale 1ns/1ps
`default_nettype none

module mag_stream_props (
    input logic                clk,
    input logic                arst_n,
    input logic                in_valid,
    input logic                in_ready,
    input mag_pkg::operand_t   in_a,
    input mag_pkg::operand_t   in_b,
    input logic                out_valid,
    input logic                out_ready,
    input mag_pkg::operand_t   out_diff,
    input mag_pkg::msb_index_t out_msb,
    input logic                out_a_larger
);

    // Stalled result keeps valid and every field
    out_hold: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_diff) && $stable(out_msb)
            && $stable(out_a_larger))
        else $error("result changed while stalled");

    // Source side obeys the same rule
    in_hold: assert property (@(posedge clk) disable iff (!arst_n)
        in_valid && !in_ready |=> in_valid && $stable(in_a) && $stable(in_b))
        else $error("input pair changed while stalled");

    // No result while reset is applied
    reset_idle: assert property (@(posedge clk) !arst_n |-> !out_valid)
        else $error("out_valid high during reset");

    // Index points at a set bit, or is 0 for a zero difference
    msb_bound: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid |-> ((out_diff == '0) ? (out_msb == '0) : ((out_diff >> out_msb) != '0)))
        else $error("out_msb above the leading one");

endmodule

bind mag_stream_top mag_stream_props props0 (
    .clk          (clk),
    .arst_n       (arst_n),
    .in_valid     (in_valid),
    .in_ready     (in_ready),
    .in_a         (in_a),
    .in_b         (in_b),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .out_diff     (out_diff),
    .out_msb      (out_msb),
    .out_a_larger (out_a_larger)
);

`default_nettype wire

/* tb_mag_stream.sv */
// Testbench for the streaming magnitude comparator
// Replays the trace with random input gaps and output back-pressure

`timescale 1ns/1ps
`default_nettype none

module tb_mag_stream;

    import mag_pkg::*;

    // Modes for out_ready
    localparam int ready_random = 0;
    localparam int ready_low    = 1;
    localparam int ready_high   = 2;

    logic       clk = 1'b0;
    logic       arst_n;
    logic       in_valid;
    logic       in_ready;
    operand_t   in_a;
    operand_t   in_b;
    logic       out_valid;
    logic       out_ready;
    operand_t   out_diff;
    msb_index_t out_msb;
    logic       out_a_larger;

    // Trace columns
    operand_t   trace_a[$];
    operand_t   trace_b[$];
    operand_t   trace_diff[$];
    msb_index_t trace_msb[$];
    logic       trace_flag[$];
    // Trace line of every pair in flight, oldest first
    int         exp_q[$];

    logic [31:0] lfsr = 32'h3a39_edb4;
    int          n_lines = 0;
    int          offer_idx = 0;
    int          offer_limit = 0;
    logic        offer_taken = 1'b0;
    int          ready_mode = ready_random;
    int          received = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;
    logic        limit_ready = 1'b0;
    int          diff_errors = 0;
    int          msb_errors = 0;
    int          flag_errors = 0;
    int          other_errors = 0;

    mag_stream_top dut0 (
        .clk          (clk),
        .arst_n       (arst_n),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_a         (in_a),
        .in_b         (in_b),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_diff     (out_diff),
        .out_msb      (out_msb),
        .out_a_larger (out_a_larger)
    );

    always #5 clk = ~clk;

    // Galois LFSR, one step per random bit
    function automatic logic next_random_bit();
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        return lfsr[0];
    endfunction

    task automatic check_diff(input string name, input operand_t expected,
                              input operand_t actual);
        if (actual !== expected) begin
            diff_errors++;
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_msb(input string name, input msb_index_t expected,
                             input msb_index_t actual);
        if (actual !== expected) begin
            msb_errors++;
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            flag_errors++;
            $display("[FAIL] %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    // Idle state of both handshakes around reset
    task automatic check_idle(input string when);
        if (out_valid !== 1'b0 || in_ready !== 1'b1) begin
            other_errors++;
            $display("Wrong state %s: out_valid=%b in_ready=%b", when, out_valid, in_ready);
        end
    endtask

    // Pops the oldest expected pair and compares the result fields
    task automatic check_result();
        int    line_idx;
        string tag;
        if (exp_q.size() == 0) begin
            other_errors++;
            $display("A result appeared with no pair outstanding, diff %h", out_diff);
        end else begin
            line_idx = exp_q.pop_front();
            received++;
            tag = $sformatf("line %0d", line_idx + 1);
            check_diff({tag, " diff"}, trace_diff[line_idx], out_diff);
            check_msb({tag, " msb"}, trace_msb[line_idx], out_msb);
            check_flag({tag, " a_larger"}, trace_flag[line_idx], out_a_larger);
        end
    endtask

    // One clock: drive on the falling edge, then look at settled handshakes
    task automatic step_cycle(input logic gaps);
        @(negedge clk);
        cycle_count++;
        // A pending offer stays put until it is taken
        if (!in_valid || offer_taken) begin
            in_valid = 1'b0;
            if (offer_idx < offer_limit && !(gaps && next_random_bit())) begin
                in_valid = 1'b1;
                in_a     = trace_a[offer_idx % n_lines];
                in_b     = trace_b[offer_idx % n_lines];
            end
        end
        case (ready_mode)
            ready_random: out_ready = !next_random_bit();
            ready_low:    out_ready = 1'b0;
            default:      out_ready = 1'b1;
        endcase
        #1;
        // Both transfers complete on the next rising edge
        offer_taken = in_valid && in_ready;
        if (offer_taken) begin
            exp_q.push_back(offer_idx % n_lines);
            offer_idx++;
        end
        if (out_valid && out_ready) begin
            check_result();
        end
    endtask

    // Whole trace with random gaps and random back-pressure
    task automatic run_trace();
        offer_limit = n_lines;
        ready_mode  = ready_random;
        while (offer_idx < n_lines || exp_q.size() != 0) begin
            step_cycle(1'b1);
        end
        // Nothing more may come out once the trace has drained
        ready_mode = ready_high;
        repeat (5) step_cycle(1'b1);
        if (received != n_lines) begin
            other_errors++;
            $display("Trace gave %0d results for %0d pairs", received, n_lines);
        end
    endtask

    // Output stalled for 12 cycles under a steady stream of offers
    task automatic run_fill();
        logic saw_full;
        saw_full    = 1'b0;
        offer_limit = offer_idx + 12;
        ready_mode  = ready_low;
        repeat (12) begin
            step_cycle(1'b0);
            if (!in_ready) begin
                saw_full = 1'b1;
            end
            if (exp_q.size() > 6) begin
                other_errors++;
                $display("More than 6 pairs in flight: %0d", exp_q.size());
            end
        end
        // Sorter stage, four FIFO entries and the output register all occupied
        if (exp_q.size() != 6) begin
            other_errors++;
            $display("Stalled pipeline took %0d pairs instead of 6", exp_q.size());
        end
        if (!saw_full) begin
            other_errors++;
            $display("in_ready never fell while the output was stalled");
        end
        // Release and drain whatever is held
        ready_mode  = ready_high;
        offer_limit = offer_idx;
        while (exp_q.size() != 0 || (in_valid && !offer_taken)) begin
            step_cycle(1'b0);
        end
    endtask

    initial begin
        int         fd;
        int         code;
        string      line;
        operand_t   a;
        operand_t   b;
        operand_t   d;
        msb_index_t m;
        logic       f;
        arst_n    = 1'b0;
        in_valid  = 1'b0;
        in_a      = '0;
        in_b      = '0;
        out_ready = 1'b0;
        fd = $fopen("mag_trace.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                // Lines starting with # describe the columns
                if (code > 0 && line.len() > 0 && line[0] != "#") begin
                    if ($sscanf(line, "%h %h %h %h %h", a, b, d, m, f) == 5) begin
                        trace_a.push_back(a);
                        trace_b.push_back(b);
                        trace_diff.push_back(d);
                        trace_msb.push_back(m);
                        trace_flag.push_back(f);
                    end
                end
            end
            $fclose(fd);
        end
        n_lines     = trace_a.size();
        cycle_limit = 20 * n_lines + 100;
        limit_ready = 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_idle("during reset");
        end
        arst_n = 1'b1;
        #1;
        check_idle("right after reset");
        if (n_lines == 0) begin
            other_errors++;
            $display("Trace file could not be read or holds no pairs");
        end else begin
            run_trace();
            run_fill();
        end
        $display("Error counts: diff %0d, msb %0d, flag %0d, other %0d",
                 diff_errors, msb_errors, flag_errors, other_errors);
        if (diff_errors + msb_errors + flag_errors + other_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // Watchdog on the stimulus cycles
    initial begin
        wait (limit_ready);
        wait (cycle_count >= cycle_limit);
        $display("Results stopped arriving, run ended after %0d cycles", cycle_count);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* mag_trace.txt */
# Columns in hex: a b expected_diff expected_msb expected_a_larger
# One operand pair per line
0000 0000 0000 0 0
0001 0000 0001 0 1
0000 0001 0001 0 0
8000 0000 8000 f 1
0000 8000 8000 f 0
ffff 0000 ffff f 1
0000 ffff ffff f 0
1234 1234 0000 0 0
ffff ffff 0000 0 0
8001 0001 8000 f 1
0005 0003 0002 1 1
0003 0005 0002 1 0
0100 00ff 0001 0 1
00ff 0100 0001 0 0
1000 0001 0fff b 1
0002 1000 0ffe b 0
abcd 1234 9999 f 1
1234 abcd 9999 f 0
7fff 8000 0001 0 0
8000 7fff 0001 0 1
4000 0000 4000 e 1
0000 2000 2000 d 0
0400 0000 0400 a 1
0080 0000 0080 7 1
0010 0008 0008 3 1
0020 0040 0020 5 0
3000 1000 2000 d 1
c000 4000 8000 f 1
0064 00c8 0064 6 0
1111 0111 1000 c 1
fedc ba98 4444 e 1
0f0f f0f0 e1e1 f 0
5555 aaaa 5555 e 0
0007 0000 0007 2 1
0000 000f 000f 3 0
0200 01ff 0001 0 1
4321 4321 0000 0 0
9000 0fff 8001 f 1

/* project.f */
mag_pkg.sv
prefix_adder.sv
pair_sorter.sv
pair_fifo.sv
magnitude_unit.sv
mag_stream_top.sv
mag_stream_props.sv
tb_mag_stream.sv
